/* logic/disp_pkg.sv */
package disp_pkg;

  // widths with a meaning of their own
  typedef logic [15:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [7:0]  cpu_idx_t;
  typedef logic [7:0]  msg_t;

  // message codes on req.msg
  localparam msg_t MSG_START = 8'h01;
  localparam msg_t MSG_END   = 8'h02;
  localparam msg_t MSG_FORK  = 8'h03;

  typedef enum logic [1:0] {
    CTL_LOOP,
    CTL_CMD,
    CTL_MEM,
    CTL_FORK
  } ctl_state_e;

  // dispatcher toward the cpus
  typedef struct packed {
    logic     cpu_q;
    logic     active;
    cpu_idx_t index;
    addr_t    thread;
  } offer_t;

  // commands from the cpu holding the bus turn
  typedef struct packed {
    logic  read_q;
    logic  write_q;
    logic  msg_e;
    msg_t  msg;
    addr_t addr;
    data_t data;
  } cpu_req_t;

  typedef struct packed {
    logic  read_dn;
    logic  write_dn;
    data_t rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic  done;
    logic  ok;
    data_t chan;
  } fork_rsp_t;

endpackage

/* logic/dispatch_ctl.sv */
`timescale 1ns/1ps

module dispatch_ctl (
  input  logic                  clk,
  input  logic                  ext_rst_e,
  input  disp_pkg::cpu_req_t    req,
  input  disp_pkg::addr_t       next_thread,
  input  disp_pkg::cpu_idx_t    sel_index,
  input  logic                  sel_active,
  input  logic                  ins_ok,
  output disp_pkg::offer_t      offer,
  output disp_pkg::fork_rsp_t   fork_rsp,
  output logic                  pick,
  output logic                  adv,
  output logic                  start,
  output logic                  stop,
  output logic                  ins,
  output disp_pkg::addr_t       ins_addr,
  output logic                  rd,
  output logic                  wr,
  output disp_pkg::addr_t       mem_addr,
  output disp_pkg::data_t       wdata
);

  disp_pkg::ctl_state_e state;
  disp_pkg::ctl_state_e state_nxt;

  logic in_cmd;
  logic msg_go;

  // registered offer
  logic               cpu_q_r;
  logic               offer_active;
  disp_pkg::cpu_idx_t offer_index;
  disp_pkg::addr_t    offer_thread;

  // fork reply, chan kept from the fork command
  logic               fork_done;
  logic               fork_ok;
  disp_pkg::data_t    fork_chan;

  // one command per offer, read beats write beats message
  assign in_cmd = (state == disp_pkg::CTL_CMD);
  assign rd     = in_cmd && req.read_q;
  assign wr     = in_cmd && !req.read_q && req.write_q;
  assign msg_go = in_cmd && !req.read_q && !req.write_q && req.msg_e;
  assign start  = msg_go && (req.msg == disp_pkg::MSG_START);
  assign stop   = msg_go && (req.msg == disp_pkg::MSG_END);
  assign ins    = msg_go && (req.msg == disp_pkg::MSG_FORK);

  // roster and table step together with each offer
  assign pick = (state == disp_pkg::CTL_LOOP);
  assign adv  = pick;

  assign mem_addr = req.addr;
  assign wdata    = req.data;
  assign ins_addr = req.addr;

  always_comb begin
    state_nxt = state;
    case (state)
      disp_pkg::CTL_LOOP: state_nxt = disp_pkg::CTL_CMD;
      disp_pkg::CTL_CMD: begin
        if (rd || wr) begin
          state_nxt = disp_pkg::CTL_MEM;
        end else if (start || stop) begin
          state_nxt = disp_pkg::CTL_LOOP;
        end else if (ins) begin
          state_nxt = disp_pkg::CTL_FORK;
        end
      end
      // done strobe is out during these, back to offering next
      disp_pkg::CTL_MEM:  state_nxt = disp_pkg::CTL_LOOP;
      disp_pkg::CTL_FORK: state_nxt = disp_pkg::CTL_LOOP;
      default:            state_nxt = disp_pkg::CTL_LOOP;
    endcase
  end

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state     <= disp_pkg::CTL_LOOP;
      cpu_q_r   <= 1'b0;
      fork_done <= 1'b0;
    end else begin
      state     <= state_nxt;
      cpu_q_r   <= pick;
      fork_done <= ins;
    end
  end

  always_ff @(posedge clk) begin
    if (pick) begin
      offer_active <= sel_active;
      offer_index  <= sel_index;
      offer_thread <= next_thread;
    end
    // ok reflects the table before this insert
    if (ins) begin
      fork_ok   <= ins_ok;
      fork_chan <= req.data;
    end
  end

  assign offer = '{cpu_q: cpu_q_r, active: offer_active, index: offer_index,
                   thread: offer_thread};
  assign fork_rsp = '{done: fork_done, ok: fork_ok, chan: fork_chan};

endmodule

/* logic/cpu_roster.sv */
`timescale 1ns/1ps

module cpu_roster #(
  parameter int N_CPUS = 4
) (
  input  logic               clk,
  input  logic               ext_rst_e,
  input  logic               pick,
  input  logic               start,
  input  logic               stop,
  output disp_pkg::cpu_idx_t sel_index,
  output logic               sel_active
);

  disp_pkg::cpu_idx_t act_cnt;
  disp_pkg::cpu_idx_t inact_cnt;
  disp_pkg::cpu_idx_t rr_ptr;
  disp_pkg::cpu_idx_t rr_nxt;
  logic               prev_inact;
  logic               inact_offer;

  // idle cpus get every other turn, or every turn while none runs
  assign inact_offer = (inact_cnt != '0) && (!prev_inact || (act_cnt == '0));
  assign rr_nxt      = (rr_ptr + 8'd1 >= act_cnt) ? '0 : rr_ptr + 8'd1;

  assign sel_active = !inact_offer;
  assign sel_index  = inact_offer ? act_cnt : rr_nxt;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      act_cnt    <= '0;
      inact_cnt  <= disp_pkg::cpu_idx_t'(N_CPUS);
      rr_ptr     <= '0;
      prev_inact <= 1'b0;
    end else begin
      if (pick) begin
        prev_inact <= inact_offer;
        if (!inact_offer) begin
          rr_ptr <= rr_nxt;
        end
      end
      if (start && (inact_cnt != '0)) begin
        act_cnt   <= act_cnt + 8'd1;
        inact_cnt <= inact_cnt - 8'd1;
      end else if (stop && (act_cnt != '0)) begin
        act_cnt   <= act_cnt - 8'd1;
        inact_cnt <= inact_cnt + 8'd1;
        // pointer must stay inside the shrunk active set
        if (rr_ptr >= act_cnt - 8'd1) begin
          rr_ptr <= '0;
        end
      end
    end
  end

endmodule

/* logic/thread_table.sv */
`timescale 1ns/1ps

module thread_table #(
  parameter int N_THREADS = 8
) (
  input  logic            clk,
  input  logic            ext_rst_e,
  input  logic            adv,
  input  logic            ins,
  input  disp_pkg::addr_t ins_addr,
  output disp_pkg::addr_t next_thread,
  output logic            ins_ok
);

  // count runs up to N_THREADS itself
  localparam int IDX_W  = $clog2(N_THREADS + 1);
  localparam int SLOT_W = (N_THREADS > 1) ? $clog2(N_THREADS) : 1;

  typedef logic [IDX_W-1:0]  tidx_t;
  typedef logic [SLOT_W-1:0] slot_t;

  disp_pkg::addr_t tbl [N_THREADS];
  tidx_t           count;
  tidx_t           rot_ptr;
  tidx_t           rot_nxt;

  assign ins_ok      = (count < tidx_t'(N_THREADS));
  assign next_thread = tbl[slot_t'(rot_ptr)];

  // pointer wraps after the last valid entry
  assign rot_nxt = (rot_ptr + tidx_t'(1) >= count) ? '0 : rot_ptr + tidx_t'(1);

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      count   <= tidx_t'(1);
      rot_ptr <= '0;
      // boot thread at address 0
      tbl[0]  <= '0;
    end else begin
      if (adv) begin
        rot_ptr <= rot_nxt;
      end
      if (ins && ins_ok) begin
        tbl[slot_t'(count)] <= ins_addr;
        count               <= count + tidx_t'(1);
      end
    end
  end

endmodule

/* logic/shared_mem.sv */
`timescale 1ns/1ps

module shared_mem #(
  parameter int MEM_WORDS = 256
) (
  input  logic               clk,
  input  logic               ext_rst_e,
  input  logic               rd,
  input  logic               wr,
  input  disp_pkg::addr_t    addr,
  input  disp_pkg::data_t    wdata,
  output disp_pkg::mem_rsp_t mem_rsp
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  disp_pkg::data_t  mem [MEM_WORDS];
  disp_pkg::data_t  rdata_q;
  logic [IDX_W-1:0] idx;
  logic             read_dn_q;
  logic             write_dn_q;

  // address folds onto the array
  assign idx = IDX_W'(addr % disp_pkg::addr_t'(MEM_WORDS));

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[idx] <= wdata;
    end
    if (rd) begin
      rdata_q <= mem[idx];
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      read_dn_q  <= 1'b0;
      write_dn_q <= 1'b0;
    end else begin
      read_dn_q  <= rd;
      write_dn_q <= wr;
    end
  end

  assign mem_rsp = '{read_dn: read_dn_q, write_dn: write_dn_q, rdata: rdata_q};

endmodule

/* logic/cpu_dispatcher.sv */
`timescale 1ns/1ps

module cpu_dispatcher #(
  parameter int N_CPUS    = 4,
  parameter int N_THREADS = 8,
  parameter int MEM_WORDS = 256
) (
  input  logic                clk,
  input  logic                ext_rst_e,
  input  disp_pkg::cpu_req_t  req,
  output disp_pkg::offer_t    offer,
  output disp_pkg::mem_rsp_t  mem_rsp,
  output disp_pkg::fork_rsp_t fork_rsp
);

  // controller to roster
  logic               pick;
  logic               start;
  logic               stop;
  disp_pkg::cpu_idx_t sel_index;
  logic               sel_active;

  // controller to thread table
  logic               adv;
  logic               ins;
  logic               ins_ok;
  disp_pkg::addr_t    ins_addr;
  disp_pkg::addr_t    next_thread;

  // controller to memory
  logic               rd;
  logic               wr;
  disp_pkg::addr_t    mem_addr;
  disp_pkg::data_t    wdata;

  dispatch_ctl u_ctl (
    .clk(clk), .ext_rst_e(ext_rst_e), .req(req),
    .next_thread(next_thread), .sel_index(sel_index), .sel_active(sel_active),
    .ins_ok(ins_ok), .offer(offer), .fork_rsp(fork_rsp),
    .pick(pick), .adv(adv), .start(start), .stop(stop),
    .ins(ins), .ins_addr(ins_addr), .rd(rd), .wr(wr),
    .mem_addr(mem_addr), .wdata(wdata)
  );

  cpu_roster #(.N_CPUS(N_CPUS)) u_roster (
    .clk(clk), .ext_rst_e(ext_rst_e), .pick(pick), .start(start), .stop(stop),
    .sel_index(sel_index), .sel_active(sel_active)
  );

  thread_table #(.N_THREADS(N_THREADS)) u_threads (
    .clk(clk), .ext_rst_e(ext_rst_e), .adv(adv), .ins(ins), .ins_addr(ins_addr),
    .next_thread(next_thread), .ins_ok(ins_ok)
  );

  shared_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
    .clk(clk), .ext_rst_e(ext_rst_e), .rd(rd), .wr(wr), .addr(mem_addr),
    .wdata(wdata), .mem_rsp(mem_rsp)
  );

endmodule

/* tb/cpu_dispatcher_tb.sv */
`timescale 1ns/1ps

module cpu_dispatcher_tb;

  localparam int N_CPUS     = 4;
  localparam int N_THREADS  = 8;
  localparam int MEM_WORDS  = 256;
  localparam int N_CMDS     = 300;
  localparam int MAX_CYCLES = N_CMDS * 6 + 100;

  localparam int T_RESET  = 0;
  localparam int T_MEM    = 1;
  localparam int T_ROSTER = 2;
  localparam int T_THREAD = 3;
  localparam int T_FORK   = 4;
  localparam int T_PACE   = 5;

  logic                clk;
  logic                ext_rst_e;
  disp_pkg::cpu_req_t  req;
  disp_pkg::offer_t    offer;
  disp_pkg::mem_rsp_t  mem_rsp;
  disp_pkg::fork_rsp_t fork_rsp;
  logic [2:0]          strobes;

  string       test_name [6] = '{"reset", "memory", "roster", "threads", "fork reply", "pacing"};
  int          checks [6];
  int          errors [6];
  int          cycles = 0;
  logic [31:0] lcg_state;

  // reference model state
  disp_pkg::data_t mem_model [int];
  int              written [$];
  int              threads [$];
  int              act_cnt;
  int              inact_cnt;
  int              rr_ptr;
  int              rot_ptr;
  logic            prev_inact;

  cpu_dispatcher #(
    .N_CPUS(N_CPUS), .N_THREADS(N_THREADS), .MEM_WORDS(MEM_WORDS)
  ) UUT (
    .clk(clk), .ext_rst_e(ext_rst_e), .req(req), .offer(offer),
    .mem_rsp(mem_rsp), .fork_rsp(fork_rsp)
  );

  assign strobes = {mem_rsp.read_dn, mem_rsp.write_dn, fork_rsp.done};

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:16]) % n;
  endfunction

  function automatic disp_pkg::data_t rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi[31:16], lo[31:16]};
  endfunction

  task automatic compare_value(input int t, input logic [31:0] exp, input logic [31:0] act);
    checks[t]++;
    assert (act === exp) else begin
      $display("Fail %s: expected %0h, actual %0h", test_name[t], exp, act);
      errors[t]++;
    end
  endtask

  task automatic report_test(input int t);
    $display("test %-10s %0d checks, %0d errors", test_name[t], checks[t], errors[t]);
  endtask

  // roster and rotation rules, applied once per offer
  task automatic check_offer();
    logic exp_inact;
    int   nxt;
    int   exp_index;
    nxt       = (act_cnt > 0) ? (rr_ptr + 1) % act_cnt : 0;
    exp_inact = (inact_cnt > 0) && (!prev_inact || act_cnt == 0);
    exp_index = exp_inact ? act_cnt : nxt;
    compare_value(T_ROSTER, 32'(!exp_inact), 32'(offer.active));
    compare_value(T_ROSTER, 32'(exp_index), 32'(offer.index));
    compare_value(T_THREAD, 32'(threads[rot_ptr]), 32'(offer.thread));
    prev_inact = exp_inact;
    if (!exp_inact) begin
      rr_ptr = nxt;
    end
    rot_ptr = (rot_ptr + 1) % threads.size();
  endtask

  initial begin
    int              kind;
    int              a;
    int              strobe_cyc;
    int              tot_checks;
    int              tot_errors;
    logic            got;
    logic            exp_ok;
    disp_pkg::data_t d;
    lcg_state = 32'd68;
    foreach (checks[i]) begin
      checks[i] = 0;
      errors[i] = 0;
    end
    act_cnt    = 0;
    inact_cnt  = N_CPUS;
    rr_ptr     = 0;
    rot_ptr    = 0;
    prev_inact = 1'b0;
    threads.push_back(0);
    strobe_cyc = 0;
    d          = '0;
    a          = 0;
    ext_rst_e  = 1'b1;
    req        = '0;
    repeat (8) @(posedge clk);
    #1;
    ext_rst_e = 1'b0;
    compare_value(T_RESET, 32'd0, 32'({offer.cpu_q, strobes}));

    for (int n = 0; n < N_CMDS; n++) begin
      // no strobe while waiting for the next offer
      got = 1'b0;
      while (!got) begin
        @(posedge clk);
        #1;
        compare_value(T_PACE, 32'd0, 32'(strobes));
        got = offer.cpu_q;
      end
      if (n == 0) begin
        compare_value(T_RESET, 32'd0, 32'(offer.active));
        compare_value(T_RESET, 32'd0, 32'(offer.index));
        compare_value(T_RESET, 32'd0, 32'(offer.thread));
        report_test(T_RESET);
      end else begin
        compare_value(T_PACE, 32'd2, 32'(cycles - strobe_cyc));
      end
      check_offer();

      // one command, one cycle, a cycle after the offer
      @(posedge clk);
      #1;
      kind = rand_below(5);
      if (kind == 0 && written.size() == 0) begin
        kind = 1;
      end
      req = '0;
      case (kind)
        0: begin
          // aliased address onto a written word
          a = written[rand_below(written.size())] + MEM_WORDS * rand_below(256);
          req.read_q = 1'b1;
          req.addr   = 16'(a);
        end
        1: begin
          a = rand_below(65536);
          d = rand_word();
          req.write_q = 1'b1;
          req.addr    = 16'(a);
          req.data    = d;
        end
        2: begin
          req.msg_e = 1'b1;
          req.msg   = disp_pkg::MSG_START;
        end
        3: begin
          req.msg_e = 1'b1;
          req.msg   = disp_pkg::MSG_END;
        end
        default: begin
          a = rand_below(65536);
          d = rand_word();
          req.msg_e = 1'b1;
          req.msg   = disp_pkg::MSG_FORK;
          req.addr  = 16'(a);
          req.data  = d;
        end
      endcase
      strobe_cyc = cycles;
      @(posedge clk);
      #1;
      req = '0;

      case (kind)
        0: begin
          compare_value(T_MEM, 32'd4, 32'(strobes));
          compare_value(T_MEM, mem_model[a % MEM_WORDS], mem_rsp.rdata);
          strobe_cyc = cycles;
        end
        1: begin
          compare_value(T_MEM, 32'd2, 32'(strobes));
          mem_model[a % MEM_WORDS] = d;
          written.push_back(a % MEM_WORDS);
          strobe_cyc = cycles;
        end
        2: begin
          if (inact_cnt > 0) begin
            act_cnt++;
            inact_cnt--;
          end
        end
        3: begin
          if (act_cnt > 0) begin
            act_cnt--;
            inact_cnt++;
            if (rr_ptr >= act_cnt) begin
              rr_ptr = 0;
            end
          end
        end
        default: begin
          exp_ok = (threads.size() < N_THREADS);
          compare_value(T_FORK, 32'd1, 32'(strobes));
          compare_value(T_FORK, 32'(exp_ok), 32'(fork_rsp.ok));
          compare_value(T_FORK, d, fork_rsp.chan);
          if (exp_ok) begin
            threads.push_back(a);
          end
          strobe_cyc = cycles;
        end
      endcase
    end

    tot_checks = 0;
    tot_errors = 0;
    for (int t = 1; t < 6; t++) begin
      report_test(t);
    end
    foreach (checks[t]) begin
      tot_checks += checks[t];
      tot_errors += errors[t];
    end
    $display("total: %0d checks, %0d errors", tot_checks, tot_errors);
    if (tot_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* cpu_dispatcher.f */
logic/disp_pkg.sv
logic/dispatch_ctl.sv
logic/cpu_roster.sv
logic/thread_table.sv
logic/shared_mem.sv
logic/cpu_dispatcher.sv
tb/cpu_dispatcher_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f cpu_dispatcher.f --top-module cpu_dispatcher_tb -o sim_cpu_dispatcher

out=$(./obj_dir/sim_cpu_dispatcher)
echo "$out"

if echo "$out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1
